// ==== all.f ====
+incdir+tb
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/branch_unit.sv
rtl/commit_unit.sv
rtl/rv_core.sv
tb/tb_rv_core.sv

// ==== rtl/branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit import rv_pkg::*; (
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  logic     is_branch,
  input  br_cond_e cond,
  output logic     taken
);

  logic eq;
  logic lt;
  logic ltu;
  logic hit;

  assign eq  = rs1_data == rs2_data;
  assign lt  = $signed(rs1_data) < $signed(rs2_data);
  assign ltu = rs1_data < rs2_data;

  always_comb begin
    case (cond)
      br_beq:  hit = eq;
      br_bne:  hit = !eq;
      br_blt:  hit = lt;
      br_bge:  hit = !lt;
      br_bltu: hit = ltu;
      br_bgeu: hit = !ltu;
      default: hit = 1'b0;
    endcase
  end

  // non-branch instructions never redirect
  assign taken = is_branch && hit;

endmodule

// ==== rtl/commit_unit.sv ====
`timescale 1ns/10ps

module commit_unit import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  insn_t   insn,
  input  logic    insn_valid,
  output logic    insn_ready,
  output word_t   fetch_pc,
  input  ctrl_t   ctrl,
  input  word_t   alu_result,
  input  logic    taken,
  output logic    rf_we,
  output logic    retire_valid,
  output retire_t retire,
  output logic    halted
);

  word_t pc;
  word_t next_pc;
  logic  accept;

  assign insn_ready = !halted;
  assign accept     = insn_valid && insn_ready;
  assign fetch_pc   = pc;

  // branch offset when taken and pc + 4 for everything else
  assign next_pc = taken ? pc + ctrl.imm : pc + 32'd4;

  // writes only land on the accepting edge
  assign rf_we = accept && ctrl.rd_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
      halted <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= accept;
      if (accept) begin
        pc <= next_pc;
        if (ctrl.is_halt) begin
          halted <= 1'b1;
        end
      end
    end
  end

  // retire record qualified by retire_valid
  always_ff @(posedge clk) begin
    if (accept) begin
      retire.pc <= pc;
      retire.insn <= insn;
      retire.rd <= ctrl.rd;
      retire.rd_we <= ctrl.rd_we;
      retire.rd_data <= ctrl.rd_we ? alu_result : '0;
      retire.next_pc <= next_pc;
      retire.illegal <= ctrl.illegal;
    end
  end

  // nothing retires and the pc holds while halted
  a_no_accept_halted: assert property (
    @(posedge clk) disable iff (rst)
    halted |=> !retire_valid && $stable(pc)
  ) else $error("instruction accepted while halted");

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    fetch_pc[1:0] == 2'b00
  ) else $error("fetch_pc not word aligned");

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    rd_data
);

  word_t regs [num_regs];

  // x0 is cleared by reset and the write port skips it
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // holds even right after a write aimed at x0
  a_x0_reads_zero: assert property (
    @(posedge clk) disable iff (rst)
    (rs1 == '0 |-> rs1_data == '0) and (rs2 == '0 |-> rs2_data == '0)
  ) else $error("x0 read returned nonzero data");

endmodule

// ==== rtl/rv_alu.sv ====
`timescale 1ns/10ps

module rv_alu import rv_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   result
);

  word_t sum;
  word_t diff;
  logic  lt_signed;
  logic  lt_unsigned;

  assign sum  = a + b;
  assign diff = a - b;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:    result = sum;
      alu_sub:    result = diff;
      // shifts use only the low five bits of b
      alu_sll:    result = a << b[4:0];
      alu_srl:    result = a >> b[4:0];
      alu_sra:    result = word_t'($signed(a) >>> b[4:0]);
      alu_slt:    result = {31'b0, lt_signed};
      alu_sltu:   result = {31'b0, lt_unsigned};
      alu_xor:    result = a ^ b;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      // lui passes its upper immediate straight through
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  insn_t   insn,
  input  logic    insn_valid,
  output logic    insn_ready,
  output word_t   fetch_pc,
  output logic    retire_valid,
  output retire_t retire,
  output logic    halted
);

  ctrl_t ctrl;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_b;
  word_t alu_result;
  logic  taken;
  logic  rf_we;

  rv_decoder u_decoder (
    .insn (insn),
    .ctrl (ctrl)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (ctrl.rd),
    .rd_data  (alu_result)
  );

  // operand b is the immediate for lui and register-immediate forms
  assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  rv_alu u_alu (
    .a      (rs1_data),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .result (alu_result)
  );

  branch_unit u_branch (
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .is_branch (ctrl.is_branch),
    .cond      (ctrl.br_cond),
    .taken     (taken)
  );

  commit_unit u_commit (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .insn_valid   (insn_valid),
    .insn_ready   (insn_ready),
    .fetch_pc     (fetch_pc),
    .ctrl         (ctrl),
    .alu_result   (alu_result),
    .taken        (taken),
    .rf_we        (rf_we),
    .retire_valid (retire_valid),
    .retire       (retire),
    .halted       (halted)
  );

endmodule

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/10ps

module rv_decoder import rv_pkg::*; (
  input  insn_t insn,
  output ctrl_t ctrl
);

  word_t imm_i;
  word_t imm_b;
  word_t imm_u;
  word_t shamt;

  assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
  assign imm_b = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm_31_12, 12'b0};
  // shift amount sits in the low five bits of the i immediate
  assign shamt = {27'b0, insn.i.imm[4:0]};

  always_comb begin
    logic bad;
    bad = 1'b0;
    ctrl = '0;
    ctrl.alu_op = alu_add;
    ctrl.rd = insn.r.rd;
    ctrl.rs1 = insn.r.rs1;
    ctrl.rs2 = insn.r.rs2;
    case (insn.r.opcode)
      op_lui: begin
        ctrl.alu_op = alu_pass_b;
        ctrl.use_imm = 1'b1;
        ctrl.imm = imm_u;
        ctrl.rd_we = 1'b1;
      end
      op_reg_imm: begin
        ctrl.use_imm = 1'b1;
        ctrl.imm = imm_i;
        case (insn.i.funct3)
          3'b000: ctrl.alu_op = alu_add;
          3'b010: ctrl.alu_op = alu_slt;
          3'b011: ctrl.alu_op = alu_sltu;
          3'b100: ctrl.alu_op = alu_xor;
          3'b110: ctrl.alu_op = alu_or;
          3'b111: ctrl.alu_op = alu_and;
          3'b001: begin
            ctrl.alu_op = alu_sll;
            ctrl.imm = shamt;
            bad = (insn.r.funct7 != 7'b0);
          end
          default: begin
            // funct3 101 selects a logical or arithmetic right shift
            ctrl.imm = shamt;
            ctrl.alu_op = (insn.r.funct7 == funct7_alt) ? alu_sra : alu_srl;
            bad = (insn.r.funct7 != 7'b0) && (insn.r.funct7 != funct7_alt);
          end
        endcase
        // shifts with a bad funct7 write nothing
        ctrl.rd_we = !bad;
      end
      op_reg_reg: begin
        case ({insn.r.funct7, insn.r.funct3})
          {7'b0, 3'b000}:       ctrl.alu_op = alu_add;
          {funct7_alt, 3'b000}: ctrl.alu_op = alu_sub;
          {7'b0, 3'b001}:       ctrl.alu_op = alu_sll;
          {7'b0, 3'b010}:       ctrl.alu_op = alu_slt;
          {7'b0, 3'b011}:       ctrl.alu_op = alu_sltu;
          {7'b0, 3'b100}:       ctrl.alu_op = alu_xor;
          {7'b0, 3'b101}:       ctrl.alu_op = alu_srl;
          {funct7_alt, 3'b101}: ctrl.alu_op = alu_sra;
          {7'b0, 3'b110}:       ctrl.alu_op = alu_or;
          {7'b0, 3'b111}:       ctrl.alu_op = alu_and;
          default:              bad = 1'b1;
        endcase
        ctrl.rd_we = !bad;
      end
      op_branch: begin
        ctrl.imm = imm_b;
        case (insn.b.funct3)
          3'b010, 3'b011: bad = 1'b1;
          default:        ctrl.br_cond = br_cond_e'(insn.b.funct3);
        endcase
        ctrl.is_branch = !bad;
      end
      // any environment encoding stops the core
      op_environ: ctrl.is_halt = 1'b1;
      default: bad = 1'b1;
    endcase
    ctrl.illegal = bad;
  end

  // an illegal word must retire with no side effects
  always_comb begin
    assert (!(ctrl.illegal && (ctrl.rd_we || ctrl.is_branch || ctrl.is_halt)))
      else $error("illegal instruction carries a side effect");
  end

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

  // datapath and register file geometry
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // only the opcodes this core executes
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_branch  = 7'b1100011,
    op_environ = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // branch funct3 encodings, 010 and 011 are unused
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } br_cond_e;

  // selects sub and sra/srai
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // one instruction word seen through each kept format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } u;
  } insn_t;

  typedef struct packed {
    alu_op_e  alu_op;
    logic     use_imm;
    word_t    imm;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     rd_we;
    logic     is_branch;
    br_cond_e br_cond;
    logic     is_halt;
    logic     illegal;
  } ctrl_t;

  typedef struct packed {
    word_t    pc;
    word_t    insn;
    reg_idx_t rd;
    logic     rd_we;
    word_t    rd_data;
    word_t    next_pc;
    logic     illegal;
  } retire_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it; exit status reports the result
verilator --binary --timing --assert --top-module tb_rv_core -f all.f -o tb_rv_core \
  && ./obj_dir/tb_rv_core \
  || { echo "simulation failed"; exit 1; }

// ==== tb/rv_ref_model.svh ====
// shadow register file and expected retire records from the RV32I rules

word_t shadow [num_regs];
logic  model_halted;

function automatic void clear_shadow();
  foreach (shadow[i]) begin
    shadow[i] = '0;
  end
  model_halted = 1'b0;
endfunction

function automatic word_t shadow_read(reg_idx_t idx);
  return (idx == 5'd0) ? '0 : shadow[idx];
endfunction

// funct3 picks the operation and alt selects sub or arithmetic right shift
function automatic word_t alu_expect(logic [2:0] f3, logic alt, word_t x, word_t y);
  logic signed [31:0] sx;
  sx = $signed(x) >>> y[4:0];
  case (f3)
    3'd0: return alt ? x - y : x + y;
    3'd1: return x << y[4:0];
    3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    3'd3: return (x < y) ? 32'd1 : 32'd0;
    3'd4: return x ^ y;
    3'd5: return alt ? word_t'(sx) : x >> y[4:0];
    3'd6: return x | y;
    default: return x & y;
  endcase
endfunction

function automatic retire_t predict_retire(word_t pc, word_t w);
  retire_t r;
  word_t a;
  word_t b;
  word_t res;
  word_t imm_b;
  logic [2:0] f3;
  logic [6:0] f7;
  logic legal;
  logic wr;
  logic tk;
  a = shadow_read(w[19:15]);
  b = shadow_read(w[24:20]);
  f3 = w[14:12];
  f7 = w[31:25];
  imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  legal = 1'b1;
  wr = 1'b0;
  tk = 1'b0;
  res = '0;
  case (w[6:0])
    7'b0110111: begin
      wr = 1'b1;
      res = {w[31:12], 12'h000};
    end
    7'b0010011: begin
      wr = 1'b1;
      if (f3 == 3'd1) begin
        legal = (f7 == 7'h00);
      end else if (f3 == 3'd5) begin
        legal = (f7 == 7'h00) || (f7 == 7'h20);
      end
      if (f3 == 3'd1 || f3 == 3'd5) begin
        res = alu_expect(f3, f7[5], a, {27'b0, w[24:20]});
      end else begin
        res = alu_expect(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
      end
    end
    7'b0110011: begin
      wr = 1'b1;
      legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      res = alu_expect(f3, f7[5], a, b);
    end
    7'b1100011: begin
      legal = (f3 != 3'd2) && (f3 != 3'd3);
      case (f3)
        3'd0: tk = (a == b);
        3'd1: tk = (a != b);
        3'd4: tk = $signed(a) < $signed(b);
        3'd5: tk = $signed(a) >= $signed(b);
        3'd6: tk = a < b;
        default: tk = a >= b;
      endcase
    end
    // environment call halts without a write
    7'b1110011: model_halted = 1'b1;
    default: legal = 1'b0;
  endcase
  r.pc = pc;
  r.insn = w;
  r.rd = w[11:7];
  r.rd_we = legal && wr;
  r.rd_data = r.rd_we ? res : '0;
  r.next_pc = (legal && tk) ? pc + imm_b : pc + 32'd4;
  r.illegal = !legal;
  if (r.rd_we && r.rd != 5'd0) begin
    shadow[r.rd] = res;
  end
  return r;
endfunction

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/10ps

module tb_rv_core import rv_pkg::*; ();

  logic    clk;
  logic    rst;
  insn_t   insn;
  logic    insn_valid;
  logic    insn_ready;
  word_t   fetch_pc;
  logic    retire_valid;
  retire_t retire;
  logic    halted;

  // instruction memory answering the fetch port
  word_t prog [1024];
  word_t rng_state = 32'hde89;
  // pc the core should be fetching from
  word_t exp_pc;

  rv_core DUT (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .insn_valid   (insn_valid),
    .insn_ready   (insn_ready),
    .fetch_pc     (fetch_pc),
    .retire_valid (retire_valid),
    .retire       (retire),
    .halted       (halted)
  );

  `include "rv_ref_model.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // about 130 instructions at up to 20 cycles each plus a margin
  initial begin : watchdog
    int budget;
    budget = 130 * 20 + 50;
    repeat (budget) @(posedge clk);
    $display("watchdog expired before the tests completed");
    stop_run("timeout");
  end

  function automatic word_t xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic word_t r_word(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                   reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_word(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                   logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic word_t u_word(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic word_t b_word(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                   logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic stop_run(string reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_retire(string name, retire_t exp, retire_t act);
    if (act !== exp) begin
      $display("ERR %s: expected %p, actual %p", name, exp, act);
      stop_run("retire record mismatch");
    end
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      stop_run("word mismatch");
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      stop_run("flag mismatch");
    end
  endtask

  // drive the fetch port for one cycle and check what the edge produced
  task automatic step(string name, logic valid);
    retire_t exp;
    word_t w;
    logic acc;
    exp = '0;
    check_word(name, exp_pc, fetch_pc);
    check_bit(name, !model_halted, insn_ready);
    w = prog[fetch_pc[11:2]];
    insn = w;
    insn_valid = valid;
    acc = valid && !model_halted;
    if (acc) begin
      exp = predict_retire(exp_pc, w);
      exp_pc = exp.next_pc;
    end
    @(posedge clk);
    #1;
    check_bit(name, acc, retire_valid);
    check_bit(name, model_halted, halted);
    check_word(name, exp_pc, fetch_pc);
    if (acc) begin
      check_retire(name, exp, retire);
    end
  endtask

  // place a word at the fetch address with an optional random idle gap
  task automatic issue(string name, word_t w, logic pause);
    word_t r;
    int gaps;
    prog[exp_pc[11:2]] = w;
    r = xorshift();
    gaps = pause ? int'(r[1:0]) : 0;
    repeat (gaps) step(name, 1'b0);
    step(name, 1'b1);
  endtask

  task automatic test_reset();
    check_word("reset", 32'h0, fetch_pc);
    check_bit("reset", 1'b0, retire_valid);
    check_bit("reset", 1'b0, halted);
    check_bit("reset", 1'b1, insn_ready);
    step("reset", 1'b0);
    issue("reset", i_word(3'b000, 5'd1, 5'd0, 12'h005), 1'b0);
  endtask

  task automatic test_reg_imm();
    word_t v;
    logic [11:0] imm;
    for (int k = 1; k < 8; k++) begin
      v = xorshift();
      // x7 ends up negative
      if (k == 7) begin
        v[31] = 1'b1;
      end
      issue("reg_imm", u_word(5'(k), v[31:12]), 1'b0);
      issue("reg_imm", i_word(3'b000, 5'(k), 5'(k), v[11:0]), 1'b0);
    end
    for (int f = 1; f < 8; f++) begin
      v = xorshift();
      imm = v[11:0];
      if (f == 1 || f == 5) begin
        imm = {7'b0, v[4:0]};
      end
      issue("reg_imm", i_word(3'(f), 5'(7 + f), 5'(f), imm), 1'b0);
    end
    v = xorshift();
    issue("reg_imm", i_word(3'b101, 5'd15, 5'd7, {7'b0100000, v[4:0]}), 1'b0);
    issue("reg_imm", i_word(3'b000, 5'd0, 5'd5, 12'h04d), 1'b0);
    issue("reg_imm", u_word(5'd0, v[31:12]), 1'b0);
    // x0 must still read zero here
    issue("reg_imm", r_word(7'h00, 3'b000, 5'd16, 5'd0, 5'd5), 1'b0);
  endtask

  task automatic test_reg_reg();
    logic [2:0] f3;
    logic [6:0] f7;
    for (int k = 0; k < 10; k++) begin
      f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
      f7 = (k < 8) ? 7'h00 : funct7_alt;
      issue("reg_reg", r_word(f7, f3, 5'(16 + k), 5'd7, 5'(k % 6 + 1)), 1'b0);
      issue("reg_reg", r_word(f7, f3, 5'(16 + k), 5'(k % 6 + 1), 5'd7), 1'b0);
    end
  endtask

  task automatic test_branches();
    br_cond_e conds [6];
    reg_idx_t src1 [3];
    reg_idx_t src2 [3];
    word_t v;
    logic [12:0] off;
    conds = '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
    src1 = '{5'd1, 5'd3, 5'd4};
    src2 = '{5'd1, 5'd4, 5'd3};
    v = xorshift();
    issue("branch", u_word(5'd1, v[31:12]), 1'b0);
    issue("branch", i_word(3'b000, 5'd1, 5'd1, v[11:0]), 1'b0);
    issue("branch", i_word(3'b000, 5'd3, 5'd0, 12'hffb), 1'b0);
    issue("branch", i_word(3'b000, 5'd4, 5'd0, 12'h003), 1'b0);
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        for (int d = 0; d < 2; d++) begin
          v = xorshift();
          off = 13'({v[3:0], 2'b00}) + 13'd8;
          if (d == 1) begin
            off = ~off + 13'd1;
          end
          issue("branch", b_word(conds[c], src1[p], src2[p], off), 1'b0);
        end
      end
    end
  endtask

  task automatic test_back_pressure();
    word_t v;
    for (int k = 0; k < 24; k++) begin
      v = xorshift();
      if (v[31]) begin
        issue("backpressure", i_word(v[14:12], 5'(8 + k % 8), 5'(v[2:0]), 12'(v[4:0])), 1'b1);
      end else begin
        issue("backpressure", r_word({1'b0, v[30], 5'b0}, 3'b000, 5'(8 + k % 8),
                                     5'(v[2:0]), 5'(v[6:4])), 1'b1);
      end
    end
  endtask

  task automatic test_halt();
    issue("illegal", r_word(7'h01, 3'b000, 5'd9, 5'd1, 5'd2), 1'b0);
    issue("illegal", 32'hffff_ffff, 1'b0);
    issue("halt", 32'h0000_0073, 1'b0);
    check_bit("halt", 1'b1, halted);
    repeat (10) begin
      step("halt", 1'b1);
    end
    insn_valid = 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    insn = '0;
    insn_valid = 1'b0;
    exp_pc = '0;
    // fill word is an addi carrying its own index
    for (int i = 0; i < 1024; i++) begin
      prog[i] = i_word(3'b000, 5'd30, 5'd0, 12'(i));
    end
    clear_shadow();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_reg_imm();
    test_reg_reg();
    test_branches();
    test_back_pressure();
    test_halt();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
